//--- alu.sv
`timescale 1ns/1ps
`include "alu_cluster_macros.svh"

module alu (
    input  logic                       en_in,
    input  alu_cluster_pkg::alu_ctrl_t ctrl,
    input  alu_cluster_pkg::reg_idx_t  rd_in,
    input  alu_cluster_pkg::word_t     sr0,
    input  alu_cluster_pkg::word_t     sr1,
    output logic                       en_out,
    output alu_cluster_pkg::reg_idx_t  rd_out,
    output alu_cluster_pkg::word_t     result
);
    import alu_cluster_pkg::*;

    localparam int SHAMT_W = $clog2(`WORD_W);

    logic op_add, op_sub, op_slt, op_sltu;
    logic op_and, op_or, op_nor, op_xor;
    logic op_sll, op_srl, op_sra;

    word_t              adder_b;
    logic               adder_cin;
    logic [`WORD_W:0]   adder_full;
    word_t              adder_sum;
    logic               adder_cout;
    logic               slt_bit;
    logic               sltu_bit;
    logic [SHAMT_W-1:0] shamt;
    word_t              sra_res;
    word_t              mux_res;

    assign op_add  = (ctrl == `CTRL_ALU_ADD);
    assign op_sub  = (ctrl == `CTRL_ALU_SUB);
    assign op_slt  = (ctrl == `CTRL_ALU_SLT);
    assign op_sltu = (ctrl == `CTRL_ALU_SLTU);
    assign op_and  = (ctrl == `CTRL_ALU_AND);
    assign op_or   = (ctrl == `CTRL_ALU_OR);
    assign op_nor  = (ctrl == `CTRL_ALU_NOR);
    assign op_xor  = (ctrl == `CTRL_ALU_XOR);
    assign op_sll  = (ctrl == `CTRL_ALU_SLL);
    assign op_srl  = (ctrl == `CTRL_ALU_SRL);
    assign op_sra  = (ctrl == `CTRL_ALU_SRA);

    // Compares subtract through the same adder as add and sub
    assign adder_cin  = op_sub | op_slt | op_sltu;
    assign adder_b    = adder_cin ? ~sr1 : sr1;
    assign adder_full = {1'b0, sr0} + {1'b0, adder_b} + {{`WORD_W{1'b0}}, adder_cin};
    assign {adder_cout, adder_sum} = adder_full;

    // Signs differ: sr0 negative wins. Signs equal: the difference sign decides
    assign slt_bit  = (sr0[`WORD_W-1] & ~sr1[`WORD_W-1])
                    | (~(sr0[`WORD_W-1] ^ sr1[`WORD_W-1]) & adder_sum[`WORD_W-1]);
    assign sltu_bit = ~adder_cout;

    assign shamt   = sr1[SHAMT_W-1:0];
    assign sra_res = word_t'($signed(sr0) >>> shamt);

    assign mux_res = ({`WORD_W{op_add | op_sub}} & adder_sum)
                   | ({`WORD_W{op_slt}}  & {{(`WORD_W-1){1'b0}}, slt_bit})
                   | ({`WORD_W{op_sltu}} & {{(`WORD_W-1){1'b0}}, sltu_bit})
                   | ({`WORD_W{op_and}}  & (sr0 & sr1))
                   | ({`WORD_W{op_or}}   & (sr0 | sr1))
                   | ({`WORD_W{op_nor}}  & ~(sr0 | sr1))
                   | ({`WORD_W{op_xor}}  & (sr0 ^ sr1))
                   | ({`WORD_W{op_sll}}  & (sr0 << shamt))
                   | ({`WORD_W{op_srl}}  & (sr0 >> shamt))
                   | ({`WORD_W{op_sra}}  & sra_res);

    assign en_out = en_in;
    assign result = en_out ? mux_res : '0;
    assign rd_out = en_out ? rd_in : '0;

endmodule

//--- alu_cluster.f
+incdir+.
alu_cluster_pkg.sv
alu.sv
alu_pipe.sv
wb_arbiter.sv
reg_file.sv
alu_cluster.sv
tb_alu_cluster.sv

//--- alu_cluster.sv
`timescale 1ns/1ps

module alu_cluster (
    input                               clk,
    input                               rst_n,
    input  logic [1:0]                  uop_valid,
    input  alu_cluster_pkg::uop_t [1:0] uop,
    output logic [1:0]                  credit,
    output alu_cluster_pkg::wb_t        wb
);
    import alu_cluster_pkg::*;

    localparam int NUM_PIPES = 2;

    logic [NUM_PIPES-1:0]       pipe_req;
    logic [NUM_PIPES-1:0]       pipe_grant;
    wb_t [NUM_PIPES-1:0]        pipe_res;
    reg_idx_t [2*NUM_PIPES-1:0] rf_idx;
    word_t [2*NUM_PIPES-1:0]    rf_data;

    // Pipe p owns read ports 2p and 2p+1
    for (genvar p = 0; p < NUM_PIPES; p++) begin : g_pipe
        alu_pipe u_pipe (
            .clk       (clk),
            .rst_n     (rst_n),
            .uop_valid (uop_valid[p]),
            .uop       (uop[p]),
            .credit    (credit[p]),
            .rs0_idx   (rf_idx[2*p]),
            .rs1_idx   (rf_idx[2*p+1]),
            .rs0_data  (rf_data[2*p]),
            .rs1_data  (rf_data[2*p+1]),
            .req       (pipe_req[p]),
            .grant     (pipe_grant[p]),
            .result    (pipe_res[p])
        );
    end

    wb_arbiter u_arbiter (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (pipe_req),
        .cand  (pipe_res),
        .grant (pipe_grant),
        .wb    (wb)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_idx  (rf_idx),
        .rd_data (rf_data),
        .wb      (wb)
    );

endmodule

//--- alu_cluster_macros.svh
`ifndef ALU_CLUSTER_MACROS_SVH
`define ALU_CLUSTER_MACROS_SVH

// Datapath and index widths
`define WORD_W      32
`define REG_IDX_W   5
`define TAG_W       6
`define CTRL_W      4

// Entries per issue queue, also the dispatcher's starting credit count
`define QUEUE_DEPTH 4

// ALU operation codes
`define CTRL_ALU_ADD  4'd0
`define CTRL_ALU_SUB  4'd1
`define CTRL_ALU_SLT  4'd2
`define CTRL_ALU_SLTU 4'd3
`define CTRL_ALU_AND  4'd4
`define CTRL_ALU_OR   4'd5
`define CTRL_ALU_NOR  4'd6
`define CTRL_ALU_XOR  4'd7
`define CTRL_ALU_SLL  4'd8
`define CTRL_ALU_SRL  4'd9
`define CTRL_ALU_SRA  4'd10

`endif

//--- alu_cluster_pkg.sv
`include "alu_cluster_macros.svh"

package alu_cluster_pkg;

    typedef logic [`WORD_W-1:0]    word_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`TAG_W-1:0]     tag_t;
    typedef logic [`CTRL_W-1:0]    alu_ctrl_t;

    // Decoded micro-op as handed over by the dispatcher
    typedef struct packed {
        tag_t      tag;
        alu_ctrl_t ctrl;
        reg_idx_t  rd;
        reg_idx_t  rs0;
        reg_idx_t  rs1;
        logic      use_imm;
        word_t     imm;
    } uop_t;

    // One writeback, either a pipe's candidate or the bus itself
    typedef struct packed {
        logic     valid;
        tag_t     tag;
        reg_idx_t rd;
        word_t    result;
    } wb_t;

endpackage

//--- alu_pipe.sv
`timescale 1ns/1ps
`include "alu_cluster_macros.svh"

module alu_pipe (
    input                             clk,
    input                             rst_n,
    input  logic                      uop_valid,
    input  alu_cluster_pkg::uop_t     uop,
    output logic                      credit,
    output alu_cluster_pkg::reg_idx_t rs0_idx,
    output alu_cluster_pkg::reg_idx_t rs1_idx,
    input  alu_cluster_pkg::word_t    rs0_data,
    input  alu_cluster_pkg::word_t    rs1_data,
    output logic                      req,
    input  logic                      grant,
    output alu_cluster_pkg::wb_t      result
);
    import alu_cluster_pkg::*;

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);

    uop_t             q_mem [`QUEUE_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;

    uop_t     head;
    logic     head_valid;
    logic     pop;
    word_t    op1;
    logic     alu_en_out;
    reg_idx_t alu_rd;
    word_t    alu_res;

    logic     res_valid;
    tag_t     res_tag;
    reg_idx_t res_rd;
    word_t    res_data;

    assign head       = q_mem[rd_ptr];
    assign head_valid = (count != '0);

    // Head moves on when the result register is free or drains this cycle
    assign pop    = head_valid && (!res_valid || grant);
    assign credit = pop;

    assign rs0_idx = head.rs0;
    assign rs1_idx = head.rs1;
    assign op1     = head.use_imm ? head.imm : rs1_data;

    alu u_alu (
        .en_in  (head_valid),
        .ctrl   (head.ctrl),
        .rd_in  (head.rd),
        .sr0    (rs0_data),
        .sr1    (op1),
        .en_out (alu_en_out),
        .rd_out (alu_rd),
        .result (alu_res)
    );

    // The dispatcher only sends with a credit in hand, so the queue never overflows
    always_ff @(posedge clk) begin
        if (uop_valid) begin
            q_mem[wr_ptr] <= uop;
        end
    end

    // Depth is a power of two so the pointers wrap on their own
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (uop_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (uop_valid && !pop) begin
                count <= count + 1'b1;
            end else if (!uop_valid && pop) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else if (pop) begin
            res_valid <= alu_en_out;
        end else if (grant) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            res_tag  <= head.tag;
            res_rd   <= alu_rd;
            res_data <= alu_res;
        end
    end

    assign req    = res_valid;
    assign result = '{valid: res_valid, tag: res_tag, rd: res_rd, result: res_data};

endmodule

//--- reg_file.sv
`timescale 1ns/1ps
`include "alu_cluster_macros.svh"

module reg_file (
    input                                   clk,
    input                                   rst_n,
    input  alu_cluster_pkg::reg_idx_t [3:0] rd_idx,
    output alu_cluster_pkg::word_t [3:0]    rd_data,
    input  alu_cluster_pkg::wb_t            wb
);
    import alu_cluster_pkg::*;

    localparam int NUM_REGS  = 1 << `REG_IDX_W;
    localparam int NUM_PORTS = 4;

    word_t regs [NUM_REGS];

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            rd_data[i] = (rd_idx[i] == '0) ? '0 : regs[rd_idx[i]];
        end
    end

    // Register 0 is hardwired, so writes aimed at it are dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.result;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module tb_alu_cluster -f alu_cluster.f

out=$(./obj_dir/Vtb_alu_cluster)
echo "$out"

echo "$out" | grep -qx "=== PASS ==="

//--- tb_alu_cluster_tests.svh
task automatic reset_state();
    int eb;
    eb = errors;
    @(negedge clk);
    if (credit !== 2'b00) begin
        report_problem("credit not low after reset");
    end
    if (wb.valid !== 1'b0) begin
        report_problem("writeback valid not low after reset");
    end
    // Every register must read zero straight after reset
    for (int i = 0; i < 32; i++) begin
        dispatch_one(i % 2, make_uop(`CTRL_ALU_ADD, i, 0, i, 1'b0, '0));
    end
    drain();
    report_test("reset", eb);
endtask

task automatic every_operation();
    int eb;
    alu_ctrl_t ops [11];
    eb = errors;
    ops = '{`CTRL_ALU_ADD, `CTRL_ALU_SUB, `CTRL_ALU_SLT, `CTRL_ALU_SLTU, `CTRL_ALU_AND,
            `CTRL_ALU_OR, `CTRL_ALU_NOR, `CTRL_ALU_XOR, `CTRL_ALU_SLL, `CTRL_ALU_SRL,
            `CTRL_ALU_SRA};
    dispatch_one(0, make_uop(`CTRL_ALU_ADD, 1, 0, 0, 1'b1, 32'hffff_fff0));
    dispatch_one(1, make_uop(`CTRL_ALU_ADD, 2, 0, 0, 1'b1, 32'd5));
    dispatch_one(0, make_uop(`CTRL_ALU_ADD, 3, 0, 0, 1'b1, 32'h8000_0000));
    dispatch_one(1, make_uop(`CTRL_ALU_ADD, 4, 0, 0, 1'b1, 32'd37));
    dispatch_one(0, make_uop(`CTRL_ALU_ADD, 5, 0, 0, 1'b1, 32'd31));
    drain();
    for (int i = 0; i < 11; i++) begin
        dispatch_one(i % 2, make_uop(ops[i], 6 + i, 1, 2, 1'b0, '0));
        dispatch_one((i + 1) % 2, make_uop(ops[i], 17 + i, 3, 4, 1'b0, '0));
    end
    // Shift by exactly 31, and by an immediate whose low 5 bits are small
    dispatch_one(0, make_uop(`CTRL_ALU_SLL, 28, 2, 5, 1'b0, '0));
    dispatch_one(1, make_uop(`CTRL_ALU_SRA, 29, 1, 5, 1'b0, '0));
    dispatch_one(0, make_uop(`CTRL_ALU_SRL, 30, 3, 0, 1'b1, 32'h0000_0041));
    drain();
    report_test("operations", eb);
endtask

task automatic reg0_and_chain();
    int eb;
    eb = errors;
    dispatch_one(0, make_uop(`CTRL_ALU_ADD, 0, 0, 0, 1'b1, 32'h1234));
    drain();
    dispatch_one(1, make_uop(`CTRL_ALU_ADD, 1, 0, 0, 1'b0, '0));
    dispatch_one(0, make_uop(`CTRL_ALU_ADD, 8, 0, 0, 1'b1, 32'd3));
    dispatch_one(1, make_uop(`CTRL_ALU_ADD, 9, 0, 0, 1'b1, 32'd10));
    drain();
    for (int i = 0; i < 5; i++) begin
        dispatch_one(i % 2, make_uop(`CTRL_ALU_ADD, 8, 8, 9, 1'b0, '0));
        drain();
    end
    dispatch_one(0, make_uop(`CTRL_ALU_ADD, 10, 8, 0, 1'b0, '0));
    drain();
    check_word(last_res, 32'd53, "accumulated chain");
    if (last_lat != 2) begin
        report_problem($sformatf("idle latency was %0d cycles instead of 2", last_lat));
    end
    report_test("reg0_chain", eb);
endtask

task automatic credit_backpressure();
    int eb;
    eb = errors;
    for (int i = 0; i < 12; i++) begin
        dispatch(2'b11, make_uop(`CTRL_ALU_ADD, 10 + i % 4, 0, 0, 1'b1, word_t'(i)),
                 make_uop(`CTRL_ALU_XOR, 20 + i % 4, 0, 0, 1'b1, word_t'(i * 7)));
    end
    drain();
    idle();
    for (int p = 0; p < 2; p++) begin
        if (issued[p] != returned[p]) begin
            report_problem($sformatf("pipe %0d issued %0d uops but returned %0d credits",
                                     p, issued[p], returned[p]));
        end
    end
    report_test("credits", eb);
endtask

task automatic arbitration_fairness();
    int eb;
    eb = errors;
    fair_viol = 0;
    have_last = 1'b0;
    fair_on   = 1'b1;
    for (int i = 0; i < 8; i++) begin
        dispatch(2'b11, make_uop(`CTRL_ALU_OR, 11, 0, 0, 1'b1, word_t'(i)),
                 make_uop(`CTRL_ALU_OR, 21, 0, 0, 1'b1, word_t'(i + 100)));
    end
    drain();
    fair_on = 1'b0;
    if (fair_viol != 0) begin
        report_problem($sformatf("one pipe won the bus twice in a row %0d times", fair_viol));
    end
    report_test("fairness", eb);
endtask

// Sources with a writeback still in flight fall back to register 0
function automatic int pick_src(input int p);
    int r;
    r = 16 * p + 1 + int'($urandom % 15);
    return (pend[r] == 0) ? r : 0;
endfunction

function automatic uop_t random_uop(input int p);
    return make_uop(alu_ctrl_t'($urandom % 11), 16 * p + 1 + int'($urandom % 15),
                    pick_src(p), pick_src(p), logic'($urandom % 2), $urandom);
endfunction

task automatic random_mix();
    int eb;
    eb = errors;
    for (int i = 0; i < 100; i++) begin
        dispatch(2'b11, random_uop(0), random_uop(1));
    end
    drain();
    report_test("random", eb);
endtask

//--- tb_alu_cluster.sv
`timescale 1ns/1ps
`include "alu_cluster_macros.svh"

module tb_alu_cluster;
    import alu_cluster_pkg::*;

    // 312 uops are issued across all tests
    localparam int TOTAL_UOPS = 312;
    localparam int CYCLE_LIMIT = 8 * TOTAL_UOPS + 200;

    typedef struct {
        tag_t     tag;
        reg_idx_t rd;
        word_t    result;
        int       disp;
    } exp_t;

    logic       clk;
    logic       rst_n;
    logic [1:0] uop_valid;
    uop_t [1:0] uop;
    logic [1:0] credit;
    wb_t        wb;

    exp_t     exp_q0 [$];
    exp_t     exp_q1 [$];
    word_t    shadow [32];
    int       pend [32];
    int       cred [2];
    int       issued [2];
    int       returned [2];
    logic [4:0] tagc [2];
    int       cyc;
    int       errors;
    int       checks;
    int       tests;
    int       failed_tests;
    int       last_lat;
    word_t    last_res;
    int       last_p;
    logic     have_last;
    logic     fair_on;
    int       fair_viol;

    alu_cluster UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .uop_valid (uop_valid),
        .uop       (uop),
        .credit    (credit),
        .wb        (wb)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_word(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_tag(input tag_t got, input tag_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_reg_idx(input reg_idx_t got, input reg_idx_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    // Reference operation rules
    function automatic word_t model_op(input alu_ctrl_t ctrl, input word_t a, input word_t b);
        case (ctrl)
            `CTRL_ALU_ADD:  return a + b;
            `CTRL_ALU_SUB:  return a - b;
            `CTRL_ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `CTRL_ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            `CTRL_ALU_AND:  return a & b;
            `CTRL_ALU_OR:   return a | b;
            `CTRL_ALU_NOR:  return ~(a | b);
            `CTRL_ALU_XOR:  return a ^ b;
            `CTRL_ALU_SLL:  return a << b[4:0];
            `CTRL_ALU_SRL:  return a >> b[4:0];
            `CTRL_ALU_SRA:  return (a >> b[4:0]) | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0]));
            default:        return '0;
        endcase
    endfunction

    function automatic uop_t make_uop(input alu_ctrl_t ctrl, input int rd, input int rs0,
                                      input int rs1, input logic use_imm, input word_t imm);
        uop_t u;
        u = '0;
        u.ctrl    = ctrl;
        u.rd      = reg_idx_t'(rd);
        u.rs0     = reg_idx_t'(rs0);
        u.rs1     = reg_idx_t'(rs1);
        u.use_imm = use_imm;
        u.imm     = imm;
        return u;
    endfunction

    task automatic idle();
        @(posedge clk);
        uop_valid <= '0;
    endtask

    // Waits for credit on every requested pipe, then presents both uops in one cycle
    task automatic dispatch(input logic [1:0] v, input uop_t u0, input uop_t u1);
        uop_t u [2];
        exp_t e;
        word_t b;
        u[0] = u0;
        u[1] = u1;
        @(posedge clk);
        while ((v[0] && cred[0] == 0) || (v[1] && cred[1] == 0)) begin
            uop_valid <= '0;
            @(posedge clk);
        end
        for (int p = 0; p < 2; p++) begin
            if (v[p]) begin
                u[p].tag = tag_t'({tagc[p], p[0]});
                tagc[p]  = tagc[p] + 5'd1;
                b = u[p].use_imm ? u[p].imm : shadow[u[p].rs1];
                e.tag    = u[p].tag;
                e.rd     = u[p].rd;
                e.result = model_op(u[p].ctrl, shadow[u[p].rs0], b);
                e.disp   = cyc + 1;
                if (p == 0) begin
                    exp_q0.push_back(e);
                end else begin
                    exp_q1.push_back(e);
                end
                cred[p]--;
                issued[p]++;
                pend[u[p].rd]++;
            end
        end
        uop_valid <= v;
        uop[0]    <= u[0];
        uop[1]    <= u[1];
    endtask

    task automatic dispatch_one(input int p, input uop_t u);
        if (p == 0) begin
            dispatch(2'b01, u, '0);
        end else begin
            dispatch(2'b10, '0, u);
        end
    endtask

    task automatic drain();
        idle();
        while (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            idle();
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    // Outputs are sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        exp_t e;
        int p;
        cyc++;
        if (cyc >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end else if (rst_n) begin
            for (int i = 0; i < 2; i++) begin
                if (credit[i]) begin
                    cred[i]++;
                    returned[i]++;
                end
                if (cred[i] > `QUEUE_DEPTH) begin
                    report_problem($sformatf("credit counter of pipe %0d above queue depth", i));
                end
            end
            if (wb.valid) begin
                last_res = wb.result;
                p = int'(wb.tag[0]);
                if ((p == 0 && exp_q0.size() == 0) || (p == 1 && exp_q1.size() == 0)) begin
                    report_problem($sformatf("extra writeback with tag %h", wb.tag));
                end else begin
                    e = (p == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
                    check_tag(wb.tag, e.tag, "writeback tag");
                    check_reg_idx(wb.rd, e.rd, "writeback rd");
                    check_word(wb.result, e.result, "writeback result");
                    last_lat = cyc - e.disp;
                    pend[e.rd]--;
                    if (e.rd != '0) begin
                        shadow[e.rd] = e.result;
                    end
                    if (fair_on && have_last && p == last_p) begin
                        if ((p == 0 && exp_q1.size() != 0) || (p == 1 && exp_q0.size() != 0)) begin
                            fair_viol++;
                        end
                    end
                    last_p    = p;
                    have_last = 1'b1;
                end
            end
        end
    end

    `include "tb_alu_cluster_tests.svh"

    initial begin
        void'($urandom(32'h2ded_dc08));
        rst_n     = 1'b0;
        uop_valid = '0;
        uop       = '0;
        cyc = 0;
        errors = 0;
        checks = 0;
        tests = 0;
        failed_tests = 0;
        last_lat = 0;
        last_res = '0;
        last_p = 0;
        have_last = 1'b0;
        fair_on = 1'b0;
        fair_viol = 0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
            pend[i]   = 0;
        end
        for (int i = 0; i < 2; i++) begin
            cred[i]     = `QUEUE_DEPTH;
            issued[i]   = 0;
            returned[i] = 0;
            tagc[i]     = '0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        reset_state();
        every_operation();
        reg0_and_chain();
        credit_backpressure();
        arbitration_fairness();
        random_mix();
        $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter (
    input                              clk,
    input                              rst_n,
    input  logic [1:0]                 req,
    input  alu_cluster_pkg::wb_t [1:0] cand,
    output logic [1:0]                 grant,
    output alu_cluster_pkg::wb_t       wb
);
    import alu_cluster_pkg::*;

    // Index of the pipe that won the bus most recently
    logic last_grant;

    // On a tie the pipe that did not win last time goes first
    assign grant[0] = req[0] && (!req[1] || last_grant);
    assign grant[1] = req[1] && (!req[0] || !last_grant);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_grant <= 1'b0;
        end else if (grant != 2'b00) begin
            last_grant <= grant[1];
        end
    end

    always_comb begin
        if (grant[1]) begin
            wb = cand[1];
        end else if (grant[0]) begin
            wb = cand[0];
        end else begin
            wb = '0;
        end
    end

endmodule
